/* tb.f */
+incdir+common
common/cache_req_pkg.sv
common/cache_mem_pkg.sv
cache_core/cache_split.sv
cache_core/cache_array.sv
logic/cache_subsys_top.sv
tb/cache_assert.sv
tb/cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the cache testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module cache_tb -o cache_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/cache_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0

/* tb/cache_tb.sv */
// Directed testbench for the unaligned data cache subsystem.
// Models the backing memory with random ready delays and keeps a reference
// byte image that every read is checked against.

`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

module cache_tb;

  localparam int MEM_BYTES      = 1024;
  localparam int NUM_ACCESSES   = 2 + 16 + 7 + 20 + 4 + 200;
  localparam int TIMEOUT_CYCLES = 40 * NUM_ACCESSES;

  logic                        clk = 1'b0;
  logic                        rst;
  logic                        i_req;
  logic [`CACHE_ADDR_W-1:0]    i_addr;
  cache_req_pkg::op_t          i_op;
  cache_req_pkg::nbytes_t      i_nbytes;
  cache_req_pkg::word_t        i_wdata;
  cache_req_pkg::word_t        o_rdata;
  logic                        o_ack;
  logic                        o_mem_valid;
  logic                        o_mem_we;
  logic [`CACHE_ADDR_W-1:0]    o_mem_addr;
  cache_mem_pkg::line_t        o_mem_wdata;
  logic                        i_mem_ready = 1'b0;
  cache_mem_pkg::line_t        i_mem_rdata = '0;

  logic [7:0]                  mem_model [MEM_BYTES];  // backing memory
  logic [7:0]                  ref_mem   [MEM_BYTES];  // expected image
  int                          mem_delay = 0;
  int                          mem_xfers = 0;
  int                          wb_count  = 0;
  logic [`CACHE_ADDR_W-1:0]    last_wb_addr = '0;
  cache_mem_pkg::line_t        last_wb_data = '0;
  int                          cycle_count = 0;

  cache_subsys_top dut (
    .clk         (clk),
    .rst         (rst),
    .i_req       (i_req),
    .i_addr      (i_addr),
    .i_op        (i_op),
    .i_nbytes    (i_nbytes),
    .i_wdata     (i_wdata),
    .o_rdata     (o_rdata),
    .o_ack       (o_ack),
    .o_mem_valid (o_mem_valid),
    .o_mem_we    (o_mem_we),
    .o_mem_addr  (o_mem_addr),
    .o_mem_wdata (o_mem_wdata),
    .i_mem_ready (i_mem_ready),
    .i_mem_rdata (i_mem_rdata)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("error: timeout, the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // every byte differs with the full 10-bit address
  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a ^ ((a >> 8) * 'h3d) ^ 'ha5);
  endfunction

  function automatic logic [127:0] reference_line(input logic [9:0] base);
    logic [127:0] line;
    for (int k = 0; k < 16; k++) begin
      line[8*k +: 8] = ref_mem[base + 10'(k)];
    end
    return line;
  endfunction

  // n bytes from addr upward, zero above
  function automatic logic [63:0] expected_read(input logic [31:0] addr, input int n);
    logic [63:0] w;
    w = '0;
    for (int j = 0; j < n; j++) begin
      w[8*j +: 8] = ref_mem[10'(addr + 32'(j))];
    end
    return w;
  endfunction

  task automatic update_reference(input logic [31:0] addr, input int n, input logic [63:0] wdata);
    for (int j = 0; j < n; j++) begin
      ref_mem[10'(addr + 32'(j))] = wdata[8*j +: 8];
    end
  endtask

  // memory side, ready after 1 to 4 cycles
  always @(negedge clk) begin
    logic [9:0] base;
    if (rst) begin
      i_mem_ready = 1'b0;
      mem_delay   = 0;
    end else if (i_mem_ready) begin
      i_mem_ready = 1'b0;  // transfer done on the last edge
    end else if (o_mem_valid) begin
      if (mem_delay == 0) begin
        mem_delay = 1 + int'($urandom % 4);
      end
      mem_delay = mem_delay - 1;
      if (mem_delay == 0) begin
        base = {o_mem_addr[9:4], 4'h0};
        if (o_mem_we) begin
          check_value("o_mem_wdata", 128'(o_mem_wdata), reference_line(base));
          for (int k = 0; k < 16; k++) begin
            mem_model[base + 10'(k)] = o_mem_wdata[8*k +: 8];
          end
          wb_count++;
          last_wb_addr = o_mem_addr;
          last_wb_data = o_mem_wdata;
        end else begin
          for (int k = 0; k < 16; k++) begin
            i_mem_rdata[8*k +: 8] = mem_model[base + 10'(k)];
          end
        end
        mem_xfers++;
        i_mem_ready = 1'b1;
      end
    end
  end

  task automatic do_access(input logic [31:0] addr, input cache_req_pkg::op_t op, input int n,
                           input logic [63:0] wdata, output int cycles);
    logic [63:0] expected;
    @(negedge clk);
    i_req    = 1'b1;
    i_addr   = addr;
    i_op     = op;
    i_nbytes = cache_req_pkg::nbytes_t'(n - 1);
    i_wdata  = wdata;
    expected = expected_read(addr, n);
    cycles   = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!o_ack);
    if (op == cache_req_pkg::OP_READ) begin
      check_value("o_rdata", 128'(o_rdata), 128'(expected));
    end else begin
      update_reference(addr, n, wdata);
    end
    @(negedge clk);
    i_req = 1'b0;  // one cycle after o_ack
  endtask

  task automatic read_access(input logic [31:0] addr, input int n);
    int cycles;
    do_access(addr, cache_req_pkg::OP_READ, n, 64'h0, cycles);
  endtask

  task automatic write_access(input logic [31:0] addr, input int n);
    int cycles;
    do_access(addr, cache_req_pkg::OP_WRITE, n, {$urandom, $urandom}, cycles);
  endtask

  task automatic test_aligned_hit();
    int cycles;
    int xfers_before;
    do_access(32'h040, cache_req_pkg::OP_READ, 8, 64'h0, cycles);  // miss and refill
    xfers_before = mem_xfers;
    do_access(32'h040, cache_req_pkg::OP_READ, 8, 64'h0, cycles);
    check_value("o_ack latency", 128'(cycles), 128'(3));
    check_value("mem transfers", 128'(mem_xfers), 128'(xfers_before));
  endtask

  task automatic test_inline_writes();
    logic [31:0] addr;
    for (int n = 1; n <= 8; n++) begin
      addr = 32'h080 + 32'(16 * (n - 1)) + 32'((n * 5) % (17 - n));
      write_access(addr, n);
      read_access(addr, n);
    end
  endtask

  task automatic test_cross_reads();
    for (int off = 9; off <= 15; off++) begin
      read_access(32'h100 + 32'(16 * (off - 9)) + 32'(off), (off < 12) ? 8 : 18 - off);
    end
  endtask

  task automatic test_cross_writes();
    logic [31:0] base;
    int          off;
    for (int i = 0; i < 4; i++) begin
      base = 32'h180 + 32'(32 * i);
      off  = 9 + 2 * i;
      write_access(base + 32'(off), (off < 12) ? 8 : 18 - off);
      for (int h = 0; h < 4; h++) begin
        read_access(base + 32'(8 * h), 8);  // both lines, two halves each
      end
    end
  endtask

  task automatic test_write_back();
    int wb_before;
    write_access(32'h1d4, 4);
    wb_before = wb_count;
    read_access(32'h3d0, 8);  // same index, other tag
    check_value("write-back count", 128'(wb_count), 128'(wb_before + 1));
    check_value("o_mem_addr", 128'(last_wb_addr), 128'(32'h1d0));
    check_value("write-back line", 128'(last_wb_data), reference_line(10'h1d0));
    read_access(32'h1d0, 8);
    read_access(32'h1d8, 8);
  endtask

  task automatic test_random();
    logic [31:0]        addr;
    int                 n;
    int                 cycles;
    cache_req_pkg::op_t op;
    for (int i = 0; i < 200; i++) begin
      addr = $urandom % 512;
      n    = 1 + int'($urandom % 8);
      op   = ($urandom % 2 == 0) ? cache_req_pkg::OP_READ : cache_req_pkg::OP_WRITE;
      do_access(addr, op, n, {$urandom, $urandom}, cycles);
    end
  endtask

  initial begin
    void'($urandom(32'h75405c85));
    rst      = 1'b1;
    i_req    = 1'b0;
    i_addr   = '0;
    i_op     = cache_req_pkg::OP_READ;
    i_nbytes = '0;
    i_wdata  = '0;
    for (int a = 0; a < MEM_BYTES; a++) begin
      mem_model[a] = fill_byte(a);
      ref_mem[a]   = fill_byte(a);
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;
    test_aligned_hit();
    test_inline_writes();
    test_cross_reads();
    test_cross_writes();
    test_write_back();
    test_random();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/cache_assert.sv */
// Handshake rules at the top ports of the cache subsystem.
// Bound into every cache_subsys_top instance, so the testbench needs no wiring.

`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

module cache_assert (
  input wire                     clk,
  input wire                     rst,
  input wire                     o_ack,
  input wire                     o_mem_valid,
  input wire [`CACHE_ADDR_W-1:0] o_mem_addr,
  input wire                     i_mem_ready
);

  ack_one_cycle: assert property (@(posedge clk) disable iff (rst) o_ack |=> !o_ack)
    else $error("o_ack stayed high for two cycles");

  // command held until the memory takes it
  mem_cmd_held: assert property (@(posedge clk) disable iff (rst)
    o_mem_valid && !i_mem_ready |=> o_mem_valid && $stable(o_mem_addr))
    else $error("memory command changed before i_mem_ready");

  idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> !o_ack && !o_mem_valid)
    else $error("o_ack or o_mem_valid high right after reset");

endmodule

bind cache_subsys_top cache_assert u_assert (
  .clk         (clk),
  .rst         (rst),
  .o_ack       (o_ack),
  .o_mem_valid (o_mem_valid),
  .o_mem_addr  (o_mem_addr),
  .i_mem_ready (i_mem_ready)
);

`default_nettype wire

/* logic/cache_subsys_top.sv */
// Top level of the unaligned data cache subsystem.
// The requester talks to the splitter, and the cache array owns the
// line-wide memory port that the backing memory answers.

`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

module cache_subsys_top (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          i_req,
  input  wire  [`CACHE_ADDR_W-1:0]     i_addr,
  input  wire  cache_req_pkg::op_t     i_op,
  input  wire  cache_req_pkg::nbytes_t i_nbytes,
  input  wire  cache_req_pkg::word_t   i_wdata,
  output wire  cache_req_pkg::word_t   o_rdata,
  output wire                          o_ack,
  output wire                          o_mem_valid,
  output wire                          o_mem_we,
  output wire  [`CACHE_ADDR_W-1:0]     o_mem_addr,
  output wire  cache_mem_pkg::line_t   o_mem_wdata,
  input  wire                          i_mem_ready,
  input  wire  cache_mem_pkg::line_t   i_mem_rdata
);

  wire                          part_req;
  wire [`CACHE_ADDR_W-1:0]      part_addr;
  wire cache_req_pkg::op_t      part_op;
  wire cache_req_pkg::nbytes_t  part_nbytes;
  wire cache_req_pkg::word_t    part_wdata;
  wire cache_req_pkg::word_t    part_rdata;
  wire                          part_ack;

  cache_split u_split (
    .clk           (clk),
    .rst           (rst),
    .i_req         (i_req),
    .i_addr        (i_addr),
    .i_op          (i_op),
    .i_nbytes      (i_nbytes),
    .i_wdata       (i_wdata),
    .o_rdata       (o_rdata),
    .o_ack         (o_ack),
    .o_part_req    (part_req),
    .o_part_addr   (part_addr),
    .o_part_op     (part_op),
    .o_part_nbytes (part_nbytes),
    .o_part_wdata  (part_wdata),
    .i_part_rdata  (part_rdata),
    .i_part_ack    (part_ack)
  );

  cache_array u_array (
    .clk         (clk),
    .rst         (rst),
    .i_req       (part_req),
    .i_addr      (part_addr),
    .i_op        (part_op),
    .i_nbytes    (part_nbytes),
    .i_wdata     (part_wdata),
    .o_rdata     (part_rdata),
    .o_ack       (part_ack),
    .o_mem_valid (o_mem_valid),
    .o_mem_we    (o_mem_we),
    .o_mem_addr  (o_mem_addr),
    .o_mem_wdata (o_mem_wdata),
    .i_mem_ready (i_mem_ready),
    .i_mem_rdata (i_mem_rdata)
  );

endmodule

`default_nettype wire

/* cache_core/cache_array.sv */
// Direct-mapped write-back, write-allocate cache for accesses inside one line.
// A miss writes back a dirty victim, refills the line over the memory port
// and then looks up again. A hit acknowledges two cycles after the request.

`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

module cache_array (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          i_req,
  input  wire  [`CACHE_ADDR_W-1:0]     i_addr,
  input  wire  cache_req_pkg::op_t     i_op,
  input  wire  cache_req_pkg::nbytes_t i_nbytes,
  input  wire  cache_req_pkg::word_t   i_wdata,
  output       cache_req_pkg::word_t   o_rdata,
  output logic                         o_ack,
  output logic                         o_mem_valid,
  output logic                         o_mem_we,
  output logic [`CACHE_ADDR_W-1:0]     o_mem_addr,
  output       cache_mem_pkg::line_t   o_mem_wdata,
  input  wire                          i_mem_ready,
  input  wire  cache_mem_pkg::line_t   i_mem_rdata
);

  localparam int OFF_W  = cache_mem_pkg::OFF_W;
  localparam int IDX_W  = cache_mem_pkg::IDX_W;
  localparam int TAG_W  = cache_mem_pkg::TAG_W;
  localparam int LB     = `CACHE_LINE_BYTES;
  localparam int WBYTES = `CACHE_DATA_W / 8;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WBACK,
    ST_REFILL,
    ST_RESP
  } state_t;

  state_t                  state_q;

  cache_mem_pkg::line_t    data_q  [`CACHE_LINES];
  cache_mem_pkg::tag_t     tag_q   [`CACHE_LINES];
  logic [`CACHE_LINES-1:0] valid_q;
  logic [`CACHE_LINES-1:0] dirty_q;

  cache_mem_pkg::offset_t  off;
  cache_mem_pkg::index_t   idx;
  cache_mem_pkg::tag_t     tag;
  logic [4:0]              n_all;
  logic                    hit;
  logic                    is_write;
  logic [LB-1:0]           byte_en;
  cache_mem_pkg::line_t    byte_mask;
  cache_mem_pkg::line_t    cur_line;
  cache_mem_pkg::line_t    shifted_wdata;
  cache_mem_pkg::line_t    wr_line;
  cache_mem_pkg::line_t    rd_line;
  cache_req_pkg::word_t    word_mask;
  cache_req_pkg::word_t    rd_word;

  assign off      = i_addr[OFF_W-1:0];
  assign idx      = i_addr[OFF_W +: IDX_W];
  assign tag      = i_addr[`CACHE_ADDR_W-1 -: TAG_W];
  assign n_all    = {2'b00, i_nbytes} + 5'd1;
  assign is_write = (i_op == cache_req_pkg::OP_WRITE);

  assign cur_line = data_q[idx];
  assign hit      = valid_q[idx] && (tag_q[idx] == tag);

  // n bytes starting at off, never past the line end
  assign byte_en = ((LB'(1) << n_all) - LB'(1)) << off;

  always_comb begin
    for (int k = 0; k < LB; k++) begin
      byte_mask[8*k +: 8] = {8{byte_en[k]}};
    end
    for (int j = 0; j < WBYTES; j++) begin
      word_mask[8*j +: 8] = {8{j < n_all}};  // zero beyond the length
    end
  end

  assign shifted_wdata = cache_mem_pkg::line_t'(i_wdata) << {off, 3'b000};
  assign wr_line       = (cur_line & ~byte_mask) | (shifted_wdata & byte_mask);
  assign rd_line       = cur_line >> {off, 3'b000};
  assign rd_word       = rd_line[`CACHE_DATA_W-1:0] & word_mask;

  assign o_ack       = (state_q == ST_RESP);
  assign o_mem_valid = (state_q == ST_WBACK) || (state_q == ST_REFILL);
  assign o_mem_we    = (state_q == ST_WBACK);
  assign o_mem_wdata = cur_line;  // victim line on write-back
  assign o_mem_addr  = {(state_q == ST_WBACK) ? tag_q[idx] : tag, idx, {OFF_W{1'b0}}};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (i_req) begin
            state_q <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (hit) begin
            state_q <= ST_RESP;
            if (is_write) begin
              dirty_q[idx] <= 1'b1;
            end
          end else if (valid_q[idx] && dirty_q[idx]) begin
            state_q <= ST_WBACK;
          end else begin
            state_q <= ST_REFILL;
          end
        end
        ST_WBACK: begin
          if (i_mem_ready) begin
            state_q <= ST_REFILL;
          end
        end
        ST_REFILL: begin
          if (i_mem_ready) begin
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= 1'b0;
            state_q      <= ST_LOOKUP;  // serve the access as a hit
          end
        end
        ST_RESP: begin
          state_q <= ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_REFILL && i_mem_ready) begin
      data_q[idx] <= i_mem_rdata;
      tag_q[idx]  <= tag;
    end else if (state_q == ST_LOOKUP && hit && is_write) begin
      data_q[idx] <= wr_line;  // merge the written bytes
    end
    if (state_q == ST_LOOKUP && hit && !is_write) begin
      o_rdata <= rd_word;
    end
  end

endmodule

`default_nettype wire

/* cache_core/cache_split.sv */
// Splits a 1 to 8 byte access that crosses a line into two in-line parts.
// The parts run in order on a req/ack chain to the cache array, and the
// read data of both parts is merged into one little-endian word.

`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

module cache_split (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          i_req,
  input  wire  [`CACHE_ADDR_W-1:0]     i_addr,
  input  wire  cache_req_pkg::op_t     i_op,
  input  wire  cache_req_pkg::nbytes_t i_nbytes,
  input  wire  cache_req_pkg::word_t   i_wdata,
  output       cache_req_pkg::word_t   o_rdata,
  output logic                         o_ack,
  output logic                         o_part_req,
  output logic [`CACHE_ADDR_W-1:0]     o_part_addr,
  output       cache_req_pkg::op_t     o_part_op,
  output       cache_req_pkg::nbytes_t o_part_nbytes,
  output       cache_req_pkg::word_t   o_part_wdata,
  input  wire  cache_req_pkg::word_t   i_part_rdata,
  input  wire                          i_part_ack
);

  localparam int OFF_W  = cache_mem_pkg::OFF_W;
  localparam int BASE_W = `CACHE_ADDR_W - OFF_W;

  cache_mem_pkg::offset_t   off;
  logic [4:0]               n_all;     // total bytes, 1 to 8
  logic [4:0]               end_pos;
  logic                     second;    // access crosses the line end
  logic [4:0]               n0;
  logic [4:0]               n1;
  logic [4:0]               nb0;
  logic [4:0]               nb1;
  logic [BASE_W-1:0]        next_base;
  logic [`CACHE_ADDR_W-1:0] addr1;
  cache_req_pkg::word_t     wdata1;
  logic                     last_part;

  logic                     part_req_q;
  logic                     part_idx_q;  // 0 or 1
  logic                     ack_q;       // o_ack of the previous cycle
  cache_req_pkg::word_t     rdata0_q;

  assign off     = i_addr[OFF_W-1:0];
  assign n_all   = {2'b00, i_nbytes} + 5'd1;
  assign end_pos = {1'b0, off} + n_all;
  assign second  = end_pos > 5'(`CACHE_LINE_BYTES);

  // part 0 runs up to the line end, part 1 takes the rest
  assign n0  = second ? (5'(`CACHE_LINE_BYTES) - {1'b0, off}) : n_all;
  assign n1  = n_all - n0;
  assign nb0 = n0 - 5'd1;
  assign nb1 = n1 - 5'd1;

  assign next_base = i_addr[`CACHE_ADDR_W-1:OFF_W] + BASE_W'(1);
  assign addr1     = {next_base, {OFF_W{1'b0}}};
  assign wdata1    = i_wdata >> {n0, 3'b000};  // drop the bytes of part 0

  assign o_part_req    = part_req_q;
  assign o_part_op     = i_op;
  assign o_part_addr   = part_idx_q ? addr1 : i_addr;
  assign o_part_nbytes = part_idx_q ? nb1[2:0] : nb0[2:0];
  assign o_part_wdata  = part_idx_q ? wdata1 : i_wdata;

  assign last_part = !second || part_idx_q;
  assign o_ack     = part_req_q && i_part_ack && last_part;

  // part 1 bytes land above the n0 bytes of part 0
  assign o_rdata = second ? (rdata0_q | (i_part_rdata << {n0, 3'b000})) : i_part_rdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      part_req_q <= 1'b0;
      part_idx_q <= 1'b0;
      ack_q      <= 1'b0;
    end else begin
      ack_q <= o_ack;
      if (part_req_q) begin
        if (i_part_ack) begin
          part_req_q <= 1'b0;                   // one idle cycle between parts
          part_idx_q <= second && !part_idx_q;  // back to 0 after the last part
        end
      end else if (i_req && !ack_q) begin
        part_req_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (part_req_q && i_part_ack && !part_idx_q) begin
      rdata0_q <= i_part_rdata;
    end
  end

endmodule

`default_nettype wire

/* common/cache_mem_pkg.sv */
// Line-side types of the cache array and its memory port.
// An address splits into tag, line index and byte offset, from top to bottom.

`default_nettype none

`include "cache_settings.svh"

package cache_mem_pkg;

  localparam int OFF_W = $clog2(`CACHE_LINE_BYTES);  // byte offset bits
  localparam int IDX_W = $clog2(`CACHE_LINES);       // line index bits
  localparam int TAG_W = `CACHE_ADDR_W - IDX_W - OFF_W;

  // byte k of the line in bits 8k+7:8k
  typedef logic [`CACHE_LINE_BYTES*8-1:0] line_t;

  typedef logic [OFF_W-1:0] offset_t;

  typedef logic [IDX_W-1:0] index_t;

  typedef logic [TAG_W-1:0] tag_t;

endpackage

`default_nettype wire

/* common/cache_req_pkg.sv */
// Request-side types for the requester, the splitter and the cache array.
// Data words are little-endian, so byte 0 of an access sits in bits 7:0.

`default_nettype none

`include "cache_settings.svh"

package cache_req_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_t;

  localparam int NBYTES_W = $clog2(`CACHE_DATA_W / 8);  // 3 bits for 8 bytes

  typedef logic [NBYTES_W-1:0] nbytes_t;  // stored as count minus one

  typedef logic [`CACHE_DATA_W-1:0] word_t;

endpackage

`default_nettype wire

/* common/cache_settings.svh */
// Size settings of the unaligned data cache subsystem.
// Included by both packages and by every RTL file that needs a width.

`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// byte address width
`define CACHE_ADDR_W      32

// request data width, 1 to 8 bytes per access
`define CACHE_DATA_W      64

// line size in bytes, also the split boundary
`define CACHE_LINE_BYTES  16

// number of direct-mapped lines
`define CACHE_LINES       16

`endif
